//--- hw/ship_pkg.sv
/*
 * Signature-based reuse predictor definitions: the line signature
 * and the hit and miss events reported to the predictor.
 */
package ship_pkg;

  localparam int unsigned SigWidth = 14;

  typedef logic [SigWidth-1:0] sig_t;

  ////////////////////////////////////////////////////////////
  // predictor event
  ////////////////////////////////////////////////////////////
  // hit side comes from the lookup response cycle,
  // miss side from the fill cycle
  typedef struct packed {
    logic hit;
    sig_t hit_sig;
    logic miss;
    // signature and outcome of the evicted entry
    sig_t miss_sig;
    logic outcome;
    sig_t new_sig;
  } pred_evt_t;

endpackage

//--- hw/dcache_cfg_pkg.sv
/*
 * Data cache geometry and the structs that travel on the read,
 * fill and response ports of the cache memory block.
 */
package dcache_cfg_pkg;

  ////////////////////////////////////////////////////////////
  // geometry
  ////////////////////////////////////////////////////////////
  localparam int unsigned NumWays      = 4;
  localparam int unsigned NumSets      = 16;
  localparam int unsigned IdxWidth     = $clog2(NumSets);
  localparam int unsigned TagWidth     = 10;
  localparam int unsigned WordsPerLine = 4;
  localparam int unsigned OffWidth     = $clog2(WordsPerLine);
  localparam int unsigned WayWidth     = $clog2(NumWays);

  typedef logic [NumWays-1:0] way_vec_t;
  // one line indexed by word offset
  typedef logic [WordsPerLine-1:0][63:0] line_t;

  typedef struct packed {
    logic                vld;
    logic [TagWidth-1:0] tag;
  } tag_entry_t;

  ////////////////////////////////////////////////////////////
  // port structs
  ////////////////////////////////////////////////////////////
  typedef struct packed {
    logic [IdxWidth-1:0] idx;
    logic [OffWidth-1:0] off;
  } rd_cmd_t;

  // arrives one cycle after the acked read
  typedef struct packed {
    logic [TagWidth-1:0] tag;
    ship_pkg::sig_t      sig;
  } rd_late_t;

  typedef struct packed {
    logic                vld;
    way_vec_t            way_we;
    way_vec_t            vld_bits;
    logic [TagWidth-1:0] tag;
    logic [IdxWidth-1:0] idx;
    line_t               data;
    ship_pkg::sig_t      sig;
  } fill_t;

  typedef struct packed {
    logic     valid;
    way_vec_t hit_oh;
    way_vec_t vld_bits;
    logic [63:0] data;
  } rd_rsp_t;

  // way number of a one-hot way vector or zero for an empty one
  function automatic logic [WayWidth-1:0] way_oh2bin(way_vec_t oh);
    logic [WayWidth-1:0] bin;
    bin = '0;
    for (int w = 0; w < NumWays; w++) begin
      if (oh[w]) begin
        bin = WayWidth'(w);
      end
    end
    return bin;
  endfunction

endpackage

//--- hw/dcache_sram.sv
/*
 * Generic single-port array built from flops.
 * One access per cycle, read data registered, contents cleared on reset.
 */
`timescale 1ns/1ps

module dcache_sram #(
  parameter type         entry_t    = logic,
  parameter int unsigned NumEntries = 16
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          req_i,
  input  logic                          we_i,
  input  logic [$clog2(NumEntries)-1:0] addr_i,
  input  entry_t                        wdata_i,
  output entry_t                        rdata_o
);

  entry_t mem_q [NumEntries];
  entry_t rdata_q;

  // write has priority, a write cycle leaves the read data unchanged
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NumEntries; i++) begin
        mem_q[i] <= '0;
      end
      rdata_q <= '0;
    end else if (req_i) begin
      if (we_i) begin
        mem_q[addr_i] <= wdata_i;
      end else begin
        rdata_q <= mem_q[addr_i];
      end
    end
  end

  assign rdata_o = rdata_q;

endmodule

//--- hw/dcache_req_stage.sv
/*
 * Request stage of the cache memory block.
 * Fills win over reads, the array address is muxed between the two and
 * the lookup context is held for the cycle in which the arrays answer.
 */
`timescale 1ns/1ps

module dcache_req_stage (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                rd_req_i,
  input  dcache_cfg_pkg::rd_cmd_t             rd_cmd_i,
  input  dcache_cfg_pkg::fill_t               fill_i,
  output logic                                rd_ack_o,
  output dcache_cfg_pkg::way_vec_t            tag_req_o,
  output logic                                tag_we_o,
  output logic                                data_req_o,
  output logic [dcache_cfg_pkg::IdxWidth-1:0] arr_idx_o,
  output logic                                lkp_valid_o,
  output logic [dcache_cfg_pkg::IdxWidth-1:0] lkp_idx_o,
  output logic [dcache_cfg_pkg::OffWidth-1:0] lkp_off_o
);

  import dcache_cfg_pkg::*;

  logic                rd_acked;
  logic                lkp_valid_q;
  logic [IdxWidth-1:0] lkp_idx_q;
  logic [OffWidth-1:0] lkp_off_q;

  ////////////////////////////////////////////////////////////
  // array access
  ////////////////////////////////////////////////////////////
  // a fill stalls the read, requester holds its request
  assign rd_acked = rd_req_i & ~fill_i.vld;
  assign rd_ack_o = rd_acked;

  // fill touches one way, a read looks at all of them
  always_comb begin
    if (fill_i.vld) begin
      tag_req_o = fill_i.way_we;
    end else if (rd_acked) begin
      tag_req_o = '1;
    end else begin
      tag_req_o = '0;
    end
  end

  // tag entry is always rewritten so the valid bit can drop
  assign tag_we_o   = fill_i.vld;
  // the line write is skipped when the filled way stays invalid
  assign data_req_o = fill_i.vld & (|(fill_i.way_we & fill_i.vld_bits));

  assign arr_idx_o = fill_i.vld ? fill_i.idx : rd_cmd_i.idx;

  ////////////////////////////////////////////////////////////
  // lookup context
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lkp_valid_q <= 1'b0;
      lkp_idx_q   <= '0;
      lkp_off_q   <= '0;
    end else begin
      lkp_valid_q <= rd_acked;
      if (rd_acked) begin
        lkp_idx_q <= rd_cmd_i.idx;
        lkp_off_q <= rd_cmd_i.off;
      end
    end
  end

  assign lkp_valid_o = lkp_valid_q;
  assign lkp_idx_o   = lkp_idx_q;
  assign lkp_off_o   = lkp_off_q;

endmodule

//--- hw/dcache_lookup.sv
/*
 * Tag compare and read-out mux.
 * Builds the hit vector from the late tag, encodes the hit way and picks
 * the addressed word out of the hit line.
 */
`timescale 1ns/1ps

module dcache_lookup (
  input  logic                                                    lkp_valid_i,
  input  logic [dcache_cfg_pkg::OffWidth-1:0]                     lkp_off_i,
  input  dcache_cfg_pkg::rd_late_t                                rd_late_i,
  input  dcache_cfg_pkg::tag_entry_t [dcache_cfg_pkg::NumWays-1:0] tag_rdata_i,
  input  dcache_cfg_pkg::line_t [dcache_cfg_pkg::NumWays-1:0]     line_rdata_i,
  output dcache_cfg_pkg::rd_rsp_t                                 rd_rsp_o,
  output logic [dcache_cfg_pkg::WayWidth-1:0]                     hit_way_o
);

  import dcache_cfg_pkg::*;

  way_vec_t            vld_bits;
  way_vec_t            hit_oh;
  logic [WayWidth-1:0] hit_way;
  line_t               hit_line;

  ////////////////////////////////////////////////////////////
  // tag compare
  ////////////////////////////////////////////////////////////
  for (genvar w = 0; w < NumWays; w++) begin : gen_cmp
    assign vld_bits[w] = tag_rdata_i[w].vld;
    // only a valid entry can hit, and only in the response cycle
    assign hit_oh[w]   = lkp_valid_i & vld_bits[w] &
                         (tag_rdata_i[w].tag == rd_late_i.tag);
  end

  // at most one way holds a given tag, so the encode is exact
  assign hit_way  = way_oh2bin(hit_oh);
  assign hit_line = line_rdata_i[hit_way];

  ////////////////////////////////////////////////////////////
  // response
  ////////////////////////////////////////////////////////////
  always_comb begin
    rd_rsp_o          = '0;
    rd_rsp_o.valid    = lkp_valid_i;
    rd_rsp_o.hit_oh   = hit_oh;
    rd_rsp_o.vld_bits = vld_bits;
    // zero on a miss
    if (|hit_oh) begin
      rd_rsp_o.data = hit_line[lkp_off_i];
    end
  end

  assign hit_way_o = hit_way;

endmodule

//--- hw/ship_history.sv
/*
 * Per-line signature and outcome history for the reuse predictor.
 * A fill stores the new signature and clears the outcome, a hit sets it.
 * Reports one hit event and one miss event per cycle at most.
 */
`timescale 1ns/1ps

module ship_history (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  dcache_cfg_pkg::fill_t               fill_i,
  input  logic                                hit_i,
  input  logic [dcache_cfg_pkg::WayWidth-1:0] hit_way_i,
  input  logic [dcache_cfg_pkg::IdxWidth-1:0] lkp_idx_i,
  output ship_pkg::pred_evt_t                 pred_o
);

  import dcache_cfg_pkg::*;
  import ship_pkg::*;

  sig_t                sig_q     [NumSets][NumWays];
  logic                outcome_q [NumSets][NumWays];
  logic [WayWidth-1:0] fill_way;

  assign fill_way = way_oh2bin(fill_i.way_we);

  ////////////////////////////////////////////////////////////
  // history arrays
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int s = 0; s < NumSets; s++) begin
        for (int w = 0; w < NumWays; w++) begin
          sig_q[s][w]     <= '0;
          outcome_q[s][w] <= 1'b0;
        end
      end
    end else begin
      for (int s = 0; s < NumSets; s++) begin
        for (int w = 0; w < NumWays; w++) begin
          // fill beats a hit on the same entry
          if (fill_i.vld && fill_i.way_we[w] && fill_i.idx == IdxWidth'(s)) begin
            sig_q[s][w]     <= fill_i.sig;
            outcome_q[s][w] <= 1'b0;
          end else if (hit_i && hit_way_i == WayWidth'(w) &&
                       lkp_idx_i == IdxWidth'(s)) begin
            outcome_q[s][w] <= 1'b1;
          end
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // predictor events
  ////////////////////////////////////////////////////////////
  always_comb begin
    pred_o      = '0;
    pred_o.hit  = hit_i;
    pred_o.miss = fill_i.vld;
    if (hit_i) begin
      pred_o.hit_sig = sig_q[lkp_idx_i][hit_way_i];
    end
    // victim state is read before the fill overwrites it
    if (fill_i.vld) begin
      pred_o.miss_sig = sig_q[fill_i.idx][fill_way];
      pred_o.outcome  = outcome_q[fill_i.idx][fill_way];
      pred_o.new_sig  = fill_i.sig;
    end
  end

endmodule

//--- hw/dcache_mem_top.sv
/*
 * Cache memory block: request stage, per-way tag and data arrays,
 * tag lookup and the reuse predictor history.
 */
`timescale 1ns/1ps

module dcache_mem_top (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     rd_req_i,
  input  dcache_cfg_pkg::rd_cmd_t  rd_cmd_i,
  input  dcache_cfg_pkg::rd_late_t rd_late_i,
  input  dcache_cfg_pkg::fill_t    fill_i,
  output logic                     rd_ack_o,
  output dcache_cfg_pkg::rd_rsp_t  rd_rsp_o,
  output ship_pkg::pred_evt_t      pred_o
);

  import dcache_cfg_pkg::*;

  way_vec_t                  tag_req;
  logic                      tag_we;
  logic                      data_req;
  logic [IdxWidth-1:0]       arr_idx;
  logic                      lkp_valid;
  logic [IdxWidth-1:0]       lkp_idx;
  logic [OffWidth-1:0]       lkp_off;
  tag_entry_t [NumWays-1:0]  tag_rdata;
  line_t [NumWays-1:0]       line_rdata;
  logic [WayWidth-1:0]       hit_way;

  dcache_req_stage i_req_stage (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .rd_req_i    (rd_req_i),
    .rd_cmd_i    (rd_cmd_i),
    .fill_i      (fill_i),
    .rd_ack_o    (rd_ack_o),
    .tag_req_o   (tag_req),
    .tag_we_o    (tag_we),
    .data_req_o  (data_req),
    .arr_idx_o   (arr_idx),
    .lkp_valid_o (lkp_valid),
    .lkp_idx_o   (lkp_idx),
    .lkp_off_o   (lkp_off)
  );

  ////////////////////////////////////////////////////////////
  // one tag array and one data array per way
  ////////////////////////////////////////////////////////////
  for (genvar w = 0; w < NumWays; w++) begin : gen_ways
    dcache_sram #(
      .entry_t    (tag_entry_t),
      .NumEntries (NumSets)
    ) i_tag_sram (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .req_i   (tag_req[w]),
      .we_i    (tag_we),
      .addr_i  (arr_idx),
      .wdata_i ({fill_i.vld_bits[w], fill_i.tag}),
      .rdata_o (tag_rdata[w])
    );

    dcache_sram #(
      .entry_t    (line_t),
      .NumEntries (NumSets)
    ) i_data_sram (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .req_i   (tag_req[w]),
      .we_i    (data_req),
      .addr_i  (arr_idx),
      .wdata_i (fill_i.data),
      .rdata_o (line_rdata[w])
    );
  end

  dcache_lookup i_lookup (
    .lkp_valid_i  (lkp_valid),
    .lkp_off_i    (lkp_off),
    .rd_late_i    (rd_late_i),
    .tag_rdata_i  (tag_rdata),
    .line_rdata_i (line_rdata),
    .rd_rsp_o     (rd_rsp_o),
    .hit_way_o    (hit_way)
  );

  ship_history i_ship_history (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .fill_i    (fill_i),
    .hit_i     (|rd_rsp_o.hit_oh),
    .hit_way_i (hit_way),
    .lkp_idx_i (lkp_idx),
    .pred_o    (pred_o)
  );

endmodule

//--- tb/dcache_mem_sva.sv
/*
 * Port-level assertions for the cache memory block, bound to its top level.
 */
`timescale 1ns/1ps

module dcache_mem_sva (
  input logic                    clk_i,
  input logic                    rst_ni,
  input dcache_cfg_pkg::fill_t   fill_i,
  input logic                    rd_ack_o,
  input dcache_cfg_pkg::rd_rsp_t rd_rsp_o
);

  // at most one way may hit
  hit_onehot0: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(rd_rsp_o.hit_oh))
    else $error("more than one way hit");

  // response exactly one cycle after each ack, and only then
  rsp_after_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rd_ack_o |=> rd_rsp_o.valid)
    else $error("acked read got no response in the next cycle");

  no_rsp_without_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !rd_ack_o |=> !rd_rsp_o.valid)
    else $error("response without an ack in the previous cycle");

  no_ack_in_fill: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fill_i.vld |-> !rd_ack_o)
    else $error("read acked while a fill is active");

  fill_way_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fill_i.vld |-> $onehot(fill_i.way_we))
    else $error("fill way enable is not one-hot");

endmodule

bind dcache_mem_top dcache_mem_sva dcache_mem_sva_i (.*);

//--- tb/dcache_mem_tb.sv
/*
 * Testbench for the cache memory block.
 * Random reads and fills are checked cycle by cycle against a model
 * of the tag, data and history arrays.
 */
`timescale 1ns/1ps

module dcache_mem_tb;

  import dcache_cfg_pkg::*;
  import ship_pkg::*;

  localparam int unsigned Seed        = 32'hf70e_b17a;
  localparam int          ResetCycles = 5;
  localparam int          RandCycles  = 400;
  localparam int          MixCycles   = 2000;
  localparam int          TestCycles  = NumSets + 3 * RandCycles + MixCycles + 8;
  localparam int          WatchdogNs  = (ResetCycles + TestCycles + 500) * 10;

  logic      clk_i = 1'b0;
  logic      rst_ni;
  logic      rd_req_i;
  rd_cmd_t   rd_cmd_i;
  rd_late_t  rd_late_i;
  fill_t     fill_i;
  logic      rd_ack_o;
  rd_rsp_t   rd_rsp_o;
  pred_evt_t pred_o;

  // reference model of the arrays
  logic                m_vld  [NumSets][NumWays];
  logic [TagWidth-1:0] m_tag  [NumSets][NumWays];
  line_t               m_line [NumSets][NumWays];
  sig_t                m_sig  [NumSets][NumWays];
  logic                m_out  [NumSets][NumWays];
  // read waiting for its response
  logic                pend_vld;
  logic [IdxWidth-1:0] pend_idx;
  logic [OffWidth-1:0] pend_off;
  int                  checks;
  int                  errors;
  int                  mark_checks;
  int                  mark_errors;

  dcache_mem_top dcache_mem_top_i (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .rd_req_i  (rd_req_i),
    .rd_cmd_i  (rd_cmd_i),
    .rd_late_i (rd_late_i),
    .fill_i    (fill_i),
    .rd_ack_o  (rd_ack_o),
    .rd_rsp_o  (rd_rsp_o),
    .pred_o    (pred_o)
  );

  always #5 clk_i = ~clk_i;

  task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] got);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s exp %h got %h", name, exp, got);
    end
  endtask

  // the late tag is half the time one stored in the set, else random
  function automatic rd_late_t pick_late(input logic [IdxWidth-1:0] idx);
    rd_late_t            late;
    logic [WayWidth-1:0] way;
    way      = WayWidth'($urandom);
    late.sig = sig_t'($urandom);
    if ($urandom_range(1) == 1) begin
      late.tag = m_tag[idx][way];
    end else begin
      late.tag = TagWidth'($urandom);
    end
    return late;
  endfunction

  function automatic fill_t make_fill(input logic [IdxWidth-1:0] idx, input int inval_pct);
    fill_t               f;
    logic [WayWidth-1:0] way;
    logic                unique_tag;
    way             = WayWidth'($urandom);
    f.vld           = 1'b1;
    f.way_we        = way_vec_t'(1 << way);
    f.vld_bits      = way_vec_t'($urandom);
    f.vld_bits[way] = ($urandom_range(99) >= inval_pct);
    f.idx           = idx;
    f.sig           = sig_t'($urandom);
    for (int i = 0; i < WordsPerLine; i++) begin
      f.data[i] = {$urandom, $urandom};
    end
    // a valid tag lives in one way of a set only
    do begin
      f.tag      = TagWidth'($urandom);
      unique_tag = 1'b1;
      for (int w = 0; w < NumWays; w++) begin
        if (WayWidth'(w) != way && m_vld[idx][w] && m_tag[idx][w] == f.tag) begin
          unique_tag = 1'b0;
        end
      end
    end while (!unique_tag);
    return f;
  endfunction

  ////////////////////////////////////////////////////////////
  // one clock cycle that drives, checks and updates the model
  ////////////////////////////////////////////////////////////
  task automatic run_cycle(input logic req, input rd_cmd_t cmd, input rd_late_t late,
                           input fill_t fill);
    logic                exp_ack;
    rd_rsp_t             exp_rsp;
    pred_evt_t           exp_pred;
    logic [WayWidth-1:0] hw;
    logic [WayWidth-1:0] fw;
    @(negedge clk_i);
    rd_req_i  = req;
    rd_cmd_i  = cmd;
    rd_late_i = late;
    fill_i    = fill;
    #2;
    exp_ack  = req & ~fill.vld;
    exp_rsp  = '0;
    exp_pred = '0;
    hw       = '0;
    fw       = '0;
    if (pend_vld) begin
      exp_rsp.valid = 1'b1;
      for (int w = 0; w < NumWays; w++) begin
        exp_rsp.vld_bits[w] = m_vld[pend_idx][w];
        if (m_vld[pend_idx][w] && m_tag[pend_idx][w] == late.tag) begin
          exp_rsp.hit_oh[w] = 1'b1;
          hw                = WayWidth'(w);
        end
      end
      if (|exp_rsp.hit_oh) begin
        exp_rsp.data     = m_line[pend_idx][hw][pend_off];
        exp_pred.hit     = 1'b1;
        exp_pred.hit_sig = m_sig[pend_idx][hw];
      end
    end
    for (int w = 0; w < NumWays; w++) begin
      if (fill.way_we[w]) begin
        fw = WayWidth'(w);
      end
    end
    if (fill.vld) begin
      exp_pred.miss     = 1'b1;
      exp_pred.miss_sig = m_sig[fill.idx][fw];
      exp_pred.outcome  = m_out[fill.idx][fw];
      exp_pred.new_sig  = fill.sig;
    end
    check_val("rd_ack_o", 64'(exp_ack), 64'(rd_ack_o));
    check_val("rd_rsp_o.valid", 64'(exp_rsp.valid), 64'(rd_rsp_o.valid));
    check_val("rd_rsp_o.hit_oh", 64'(exp_rsp.hit_oh), 64'(rd_rsp_o.hit_oh));
    if (pend_vld) begin
      check_val("rd_rsp_o.vld_bits", 64'(exp_rsp.vld_bits), 64'(rd_rsp_o.vld_bits));
      check_val("rd_rsp_o.data", exp_rsp.data, rd_rsp_o.data);
    end
    check_val("pred_o.hit", 64'(exp_pred.hit), 64'(pred_o.hit));
    check_val("pred_o.hit_sig", 64'(exp_pred.hit_sig), 64'(pred_o.hit_sig));
    check_val("pred_o.miss", 64'(exp_pred.miss), 64'(pred_o.miss));
    check_val("pred_o.miss_sig", 64'(exp_pred.miss_sig), 64'(pred_o.miss_sig));
    check_val("pred_o.outcome", 64'(exp_pred.outcome), 64'(pred_o.outcome));
    check_val("pred_o.new_sig", 64'(exp_pred.new_sig), 64'(pred_o.new_sig));
    // hit first, so a fill of the same entry clears the outcome
    if (exp_pred.hit) begin
      m_out[pend_idx][hw] = 1'b1;
    end
    if (fill.vld) begin
      m_vld[fill.idx][fw] = fill.vld_bits[fw];
      m_tag[fill.idx][fw] = fill.tag;
      if (fill.vld_bits[fw]) begin
        m_line[fill.idx][fw] = fill.data;
      end
      m_sig[fill.idx][fw] = fill.sig;
      m_out[fill.idx][fw] = 1'b0;
    end
    pend_vld = exp_ack;
    if (exp_ack) begin
      pend_idx = cmd.idx;
      pend_off = cmd.off;
    end
  endtask

  task automatic run_random(input int cycles, input int fill_pct, input int req_pct,
                            input int inval_pct);
    logic                req;
    rd_cmd_t             cmd;
    fill_t               fill;
    logic [IdxWidth-1:0] fidx;
    req = 1'b0;
    cmd = '0;
    for (int c = 0; c < cycles; c++) begin
      // a stalled read is held unchanged
      if (!(req && !pend_vld)) begin
        req     = ($urandom_range(99) < req_pct);
        cmd.idx = IdxWidth'($urandom);
        cmd.off = OffWidth'($urandom);
      end
      fill = '0;
      if ($urandom_range(99) < fill_pct) begin
        // bias fills towards the set being read
        fidx = ($urandom_range(1) == 1) ? pend_idx : IdxWidth'($urandom);
        fill = make_fill(fidx, inval_pct);
      end
      run_cycle(req, cmd, pick_late(pend_idx), fill);
    end
    run_cycle(1'b0, '0, pick_late(pend_idx), '0);
  endtask

  task automatic report_test(input string name);
    $display("test %-12s checks %0d errors %0d", name, checks - mark_checks,
             errors - mark_errors);
    mark_checks = checks;
    mark_errors = errors;
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////
  initial begin
    rd_cmd_t cmd;
    void'($urandom(Seed));
    rst_ni    = 1'b0;
    rd_req_i  = 1'b0;
    rd_cmd_i  = '0;
    rd_late_i = '0;
    fill_i    = '0;
    for (int s = 0; s < NumSets; s++) begin
      for (int w = 0; w < NumWays; w++) begin
        m_vld[s][w]  = 1'b0;
        m_tag[s][w]  = '0;
        m_line[s][w] = '0;
        m_sig[s][w]  = '0;
        m_out[s][w]  = 1'b0;
      end
    end
    pend_vld    = 1'b0;
    pend_idx    = '0;
    pend_off    = '0;
    checks      = 0;
    errors      = 0;
    mark_checks = 0;
    mark_errors = 0;
    repeat (ResetCycles) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    // back-to-back reads of every set in the empty cache
    for (int s = 0; s < NumSets; s++) begin
      cmd.idx = IdxWidth'(s);
      cmd.off = OffWidth'($urandom);
      run_cycle(1'b1, cmd, pick_late(pend_idx), '0);
    end
    run_cycle(1'b0, '0, pick_late(pend_idx), '0);
    report_test("reset_reads");

    run_random(RandCycles, 50, 50, 0);
    report_test("fill_read");
    run_random(RandCycles, 40, 100, 0);
    report_test("stall_b2b");
    run_random(RandCycles, 40, 70, 50);
    report_test("inval_fill");
    run_random(MixCycles, 20, 70, 10);
    report_test("random_mix");

    $display("tests 5, checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  initial begin
    #(WatchdogNs);
    $display("watchdog expired before the tests completed");
    $display("Something failed");
    $finish;
  end

endmodule

//--- filelist.f
hw/ship_pkg.sv
hw/dcache_cfg_pkg.sv
hw/dcache_sram.sv
hw/dcache_req_stage.sv
hw/dcache_lookup.sv
hw/ship_history.sv
hw/dcache_mem_top.sv
tb/dcache_mem_sva.sv
tb/dcache_mem_tb.sv

//--- run.sh
#!/bin/sh
# compile and run the cache memory testbench with Verilator
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module dcache_mem_tb -f filelist.f --Mdir "$BUILD_DIR" -o dcache_mem_sim
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

"./$BUILD_DIR/dcache_mem_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Everything OK$" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1
